//--- logic/ldst_pkg.sv
// ==============================
// Load/store buffer package
// Widths, queue depth, access size
// and byte-mask helpers
// ==============================
`default_nettype none

package ldst_pkg;

  localparam int unsigned XLEN       = 32;
  localparam int unsigned WORD_BYTES = 4;  // Byte lanes per word
  localparam int unsigned SB_DEPTH   = 4;
  localparam int unsigned SB_PTR_W   = 2;
  localparam int unsigned SB_CNT_W   = 3;

  typedef enum logic [1:0] {
    SIZE_BYTE,
    SIZE_HALF,
    SIZE_WORD,
    SIZE_NONE
  } access_size_e;

  typedef logic [WORD_BYTES-1:0] byte_mask_t;

  function automatic byte_mask_t size_to_mask(input logic [1:0] lsb, input access_size_e size);
    case (size)
      SIZE_BYTE: return byte_mask_t'(1) << lsb;
      SIZE_HALF: return lsb[1] ? 4'b1100 : 4'b0011;  // Halves are aligned
      SIZE_WORD: return 4'b1111;
      default:   return 4'b0000;
    endcase
  endfunction

  // One byte, an aligned half or the whole word
  function automatic logic mask_legal(input byte_mask_t mask);
    case (mask)
      4'b0001, 4'b0010, 4'b0100, 4'b1000: return 1'b1;
      4'b0011, 4'b1100, 4'b1111:          return 1'b1;
      default:                            return 1'b0;
    endcase
  endfunction

  function automatic access_size_e mask_to_size(input byte_mask_t mask);
    case (mask)
      4'b0001, 4'b0010, 4'b0100, 4'b1000: return SIZE_BYTE;
      4'b0011, 4'b1100:                   return SIZE_HALF;
      4'b1111:                            return SIZE_WORD;
      default:                            return SIZE_NONE;
    endcase
  endfunction

  function automatic logic [1:0] mask_to_lsb(input byte_mask_t mask);
    case (mask)
      4'b0010:          return 2'd1;
      4'b0100, 4'b1100: return 2'd2;
      4'b1000:          return 2'd3;
      default:          return 2'd0;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- logic/store_queue.sv
// ==============================
// Store queue
// Circular queue of word stores with
// byte masks and merging at the tail
// ==============================
`timescale 1ns/1ps
`default_nettype none

module store_queue (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          push_i,
  input  logic                          pop_i,
  input  logic [ldst_pkg::XLEN-1:0]     push_addr_i,
  input  ldst_pkg::access_size_e        push_size_i,
  input  logic [ldst_pkg::XLEN-1:0]     push_wdata_i,
  output logic                          merge_ok_o,
  output logic                          full_o,
  output logic [ldst_pkg::XLEN-1:0]     head_addr_o,
  output ldst_pkg::byte_mask_t          head_mask_o,
  output logic [ldst_pkg::XLEN-1:0]     head_data_o,
  output logic [ldst_pkg::XLEN-1:0]     ent_addr_o [ldst_pkg::SB_DEPTH],
  output ldst_pkg::byte_mask_t          ent_mask_o [ldst_pkg::SB_DEPTH],
  output logic [ldst_pkg::XLEN-1:0]     ent_data_o [ldst_pkg::SB_DEPTH],
  output logic [ldst_pkg::SB_PTR_W-1:0] tail_ptr_o,
  output logic [ldst_pkg::SB_CNT_W-1:0] count_o
);

  logic [ldst_pkg::XLEN-1:0]     addr_q [ldst_pkg::SB_DEPTH];  // Word addresses
  ldst_pkg::byte_mask_t          mask_q [ldst_pkg::SB_DEPTH];
  logic [ldst_pkg::XLEN-1:0]     data_q [ldst_pkg::SB_DEPTH];  // Lane-placed data
  logic [ldst_pkg::SB_PTR_W-1:0] head_q;
  logic [ldst_pkg::SB_PTR_W-1:0] tail_q;
  logic [ldst_pkg::SB_CNT_W-1:0] count_q;

  logic [ldst_pkg::SB_PTR_W-1:0] newest;
  logic [ldst_pkg::XLEN-1:0]     push_waddr;
  ldst_pkg::byte_mask_t          push_mask;
  logic [ldst_pkg::XLEN-1:0]     push_lanes;
  ldst_pkg::byte_mask_t          merged_mask;
  logic [ldst_pkg::XLEN-1:0]     merged_data;
  logic                          append;

  assign newest     = tail_q - 1'b1;
  assign push_waddr = {push_addr_i[ldst_pkg::XLEN-1:2], 2'b00};
  assign push_mask  = ldst_pkg::size_to_mask(push_addr_i[1:0], push_size_i);

  // Copy the store data into every lane, the mask picks the live ones
  always_comb begin
    case (push_size_i)
      ldst_pkg::SIZE_BYTE: push_lanes = {4{push_wdata_i[7:0]}};
      ldst_pkg::SIZE_HALF: push_lanes = {2{push_wdata_i[15:0]}};
      default:             push_lanes = push_wdata_i;
    endcase
  end

  assign merged_mask = mask_q[newest] | push_mask;

  always_comb begin
    merged_data = data_q[newest];
    for (int b = 0; b < ldst_pkg::WORD_BYTES; b++) begin
      if (push_mask[b]) merged_data[b*8 +: 8] = push_lanes[b*8 +: 8];
    end
  end

  // Newest entry must stay put this cycle to take a merge
  assign merge_ok_o = (count_q != '0) && (addr_q[newest] == push_waddr) &&
                      ldst_pkg::mask_legal(merged_mask) && !(pop_i && (count_q == 1));
  assign append     = push_i && !merge_ok_o;
  assign full_o     = (count_q == ldst_pkg::SB_CNT_W'(ldst_pkg::SB_DEPTH));

  // ==============================
  // Entry storage
  // ==============================
  always_ff @(posedge clk_i) begin
    if (push_i && merge_ok_o) begin
      mask_q[newest] <= merged_mask;
      data_q[newest] <= merged_data;
    end else if (append) begin
      addr_q[tail_q] <= push_waddr;
      mask_q[tail_q] <= push_mask;
      data_q[tail_q] <= push_lanes;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (append) tail_q <= tail_q + 1'b1;
      if (pop_i)  head_q <= head_q + 1'b1;
      if (append && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !append) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  assign head_addr_o = addr_q[head_q];
  assign head_mask_o = mask_q[head_q];
  assign head_data_o = data_q[head_q];
  assign ent_addr_o  = addr_q;
  assign ent_mask_o  = mask_q;
  assign ent_data_o  = data_q;
  assign tail_ptr_o  = tail_q;
  assign count_o     = count_q;

endmodule

`default_nettype wire

//--- logic/store_forward.sv
// ==============================
// Store-to-load forwarding
// Collects load bytes newest first
// from queue and in-flight store
// ==============================
`timescale 1ns/1ps
`default_nettype none

module store_forward (
  input  logic [ldst_pkg::XLEN-1:0]     ld_addr_i,
  input  ldst_pkg::access_size_e        ld_size_i,
  input  logic [ldst_pkg::XLEN-1:0]     ent_addr_i [ldst_pkg::SB_DEPTH],
  input  ldst_pkg::byte_mask_t          ent_mask_i [ldst_pkg::SB_DEPTH],
  input  logic [ldst_pkg::XLEN-1:0]     ent_data_i [ldst_pkg::SB_DEPTH],
  input  logic [ldst_pkg::SB_PTR_W-1:0] tail_ptr_i,
  input  logic [ldst_pkg::SB_CNT_W-1:0] count_i,
  input  logic                          act_valid_i,
  input  logic [ldst_pkg::XLEN-1:0]     act_addr_i,
  input  ldst_pkg::byte_mask_t          act_mask_i,
  input  logic [ldst_pkg::XLEN-1:0]     act_data_i,
  output logic                          fwd_hit_o,
  output logic                          fwd_partial_o,
  output logic [ldst_pkg::XLEN-1:0]     fwd_word_o
);

  logic [ldst_pkg::XLEN-1:0]     ld_waddr;
  ldst_pkg::byte_mask_t          need_mask;
  ldst_pkg::byte_mask_t          rem_mask;   // Lanes still missing
  logic [ldst_pkg::SB_PTR_W-1:0] scan_ptr;

  assign ld_waddr  = {ld_addr_i[ldst_pkg::XLEN-1:2], 2'b00};
  assign need_mask = ldst_pkg::size_to_mask(ld_addr_i[1:0], ld_size_i);

  always_comb begin
    rem_mask   = need_mask;
    fwd_word_o = '0;
    scan_ptr   = tail_ptr_i - 1'b1;

    // Youngest entry back to the oldest
    for (int k = 0; k < ldst_pkg::SB_DEPTH; k++) begin
      if ((k < int'(count_i)) && (ent_addr_i[scan_ptr] == ld_waddr)) begin
        for (int b = 0; b < ldst_pkg::WORD_BYTES; b++) begin
          if (rem_mask[b] && ent_mask_i[scan_ptr][b]) begin
            fwd_word_o[b*8 +: 8] = ent_data_i[scan_ptr][b*8 +: 8];
            rem_mask[b]          = 1'b0;
          end
        end
      end
      scan_ptr = scan_ptr - 1'b1;
    end

    // In-flight store is older than anything queued
    if (act_valid_i && (act_addr_i == ld_waddr)) begin
      for (int b = 0; b < ldst_pkg::WORD_BYTES; b++) begin
        if (rem_mask[b] && act_mask_i[b]) begin
          fwd_word_o[b*8 +: 8] = act_data_i[b*8 +: 8];
          rem_mask[b]          = 1'b0;
        end
      end
    end
  end

  assign fwd_hit_o     = (need_mask != '0) && (rem_mask == '0);
  assign fwd_partial_o = (rem_mask != need_mask) && (rem_mask != '0);

endmodule

`default_nettype wire

//--- logic/ldst_ctrl.sv
// ==============================
// Load/store control
// Cache transaction tracking, issue
// order, drain mode and stall
// ==============================
`timescale 1ns/1ps
`default_nettype none

module ldst_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          flush_i,
  input  logic                          req_valid_i,
  input  logic                          req_we_i,
  input  logic [ldst_pkg::XLEN-1:0]     req_addr_i,
  input  ldst_pkg::access_size_e        req_size_i,
  input  logic [ldst_pkg::XLEN-1:0]     req_wdata_i,
  input  logic                          req_signed_i,
  input  logic                          merge_ok_i,
  input  logic                          full_i,
  input  logic [ldst_pkg::SB_CNT_W-1:0] count_i,
  input  logic [ldst_pkg::XLEN-1:0]     head_addr_i,
  input  ldst_pkg::byte_mask_t          head_mask_i,
  input  logic [ldst_pkg::XLEN-1:0]     head_data_i,
  input  logic                          fwd_hit_i,
  input  logic                          fwd_partial_i,
  input  logic                          dc_rsp_valid_i,
  output logic                          push_o,
  output logic                          pop_o,
  output logic                          act_valid_o,
  output logic [ldst_pkg::XLEN-1:0]     act_addr_o,
  output ldst_pkg::byte_mask_t          act_mask_o,
  output logic [ldst_pkg::XLEN-1:0]     act_data_o,
  output logic                          dc_req_valid_o,
  output logic                          dc_we_o,
  output logic [ldst_pkg::XLEN-1:0]     dc_addr_o,
  output ldst_pkg::access_size_e        dc_size_o,
  output logic [ldst_pkg::XLEN-1:0]     dc_wdata_o,
  output logic                          ld_from_fwd_o,
  output logic [1:0]                    ld_lsb_o,
  output ldst_pkg::access_size_e        ld_size_o,
  output logic                          ld_signed_o,
  output logic                          ld_valid_o,
  output logic                          stall_o
);

  logic                      act_valid_q;
  logic                      act_load_q;
  logic                      drain_q;
  logic [ldst_pkg::XLEN-1:0] act_addr_q;
  ldst_pkg::access_size_e    act_size_q;
  logic                      act_signed_q;
  ldst_pkg::byte_mask_t      act_mask_q;
  logic [ldst_pkg::XLEN-1:0] act_data_q;

  logic       is_ld;
  logic       is_st;
  logic       q_empty;
  logic       ld_active;
  logic       ld_cache;    // Load that has to go to the cache
  logic       ld_issue;
  logic       drain_busy;
  logic [1:0] head_lsb;

  assign is_ld     = req_valid_i && !req_we_i;
  assign is_st     = req_valid_i && req_we_i;
  assign q_empty   = (count_i == '0);
  assign ld_active = act_valid_q && act_load_q;
  assign head_lsb  = ldst_pkg::mask_to_lsb(head_mask_i);

  // ==============================
  // Issue selection
  // ==============================
  assign pop_o    = !act_valid_q && !q_empty;  // Head store goes first
  assign ld_cache = is_ld && !ld_active && !fwd_hit_i && !fwd_partial_i;
  assign ld_issue = ld_cache && q_empty && !act_valid_q;

  assign dc_req_valid_o = pop_o || ld_issue;
  assign dc_we_o        = pop_o;

  always_comb begin
    if (pop_o) begin
      dc_addr_o  = head_addr_i | ldst_pkg::XLEN'(head_lsb);
      dc_size_o  = ldst_pkg::mask_to_size(head_mask_i);
      dc_wdata_o = head_data_i >> {head_lsb, 3'b000};  // Store lanes moved down
    end else begin
      dc_addr_o  = req_addr_i;
      dc_size_o  = req_size_i;
      dc_wdata_o = req_wdata_i;                        // Don't care on reads
    end
  end

  // Held from issue edge to the response cycle
  always_ff @(posedge clk_i) begin
    if (dc_req_valid_o) begin
      act_load_q   <= !dc_we_o;
      act_addr_q   <= dc_addr_o;
      act_size_q   <= dc_size_o;
      act_signed_q <= req_signed_i;
      act_mask_q   <= head_mask_i;
      act_data_q   <= head_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      act_valid_q <= 1'b0;
      drain_q     <= 1'b0;
    end else begin
      if (dc_req_valid_o) begin
        act_valid_q <= 1'b1;
      end else if (dc_rsp_valid_i) begin
        act_valid_q <= 1'b0;
      end
      if (drain_q && q_empty && !act_valid_q) begin
        drain_q <= 1'b0;
      end else if (flush_i && (!q_empty || (act_valid_q && !act_load_q))) begin
        drain_q <= 1'b1;
      end
    end
  end

  assign act_valid_o = act_valid_q && !act_load_q;  // Only stores forward
  assign act_addr_o  = {act_addr_q[ldst_pkg::XLEN-1:2], 2'b00};
  assign act_mask_o  = act_mask_q;
  assign act_data_o  = act_data_q;

  // ==============================
  // Stall and load result
  // ==============================
  assign drain_busy = drain_q && (!q_empty || act_valid_q);

  assign stall_o = drain_busy ||
                   (ld_active && !dc_rsp_valid_i) ||         // Response wait
                   (is_ld && !ld_active && fwd_partial_i) || // Partial overlap
                   ld_cache ||                               // Issue or queue not empty
                   (is_st && full_i && !merge_ok_i);

  assign push_o     = is_st && !stall_o;
  assign ld_valid_o = is_ld && !stall_o;

  assign ld_from_fwd_o = !ld_active;
  assign ld_lsb_o      = ld_active ? act_addr_q[1:0] : req_addr_i[1:0];
  assign ld_size_o     = ld_active ? act_size_q : req_size_i;
  assign ld_signed_o   = ld_active ? act_signed_q : req_signed_i;

endmodule

`default_nettype wire

//--- logic/load_align.sv
// ==============================
// Load alignment
// Lane select with sign or zero
// extension
// ==============================
`timescale 1ns/1ps
`default_nettype none

module load_align (
  input  logic [ldst_pkg::XLEN-1:0] word_i,
  input  logic [1:0]                lsb_i,
  input  ldst_pkg::access_size_e    size_i,
  input  logic                      signed_i,
  output logic [ldst_pkg::XLEN-1:0] data_o
);

  logic [7:0]  byte_sel;
  logic [15:0] half_sel;
  logic        ext_bit;

  assign byte_sel = word_i[{lsb_i, 3'b000} +: 8];
  assign half_sel = word_i[{lsb_i[1], 4'b0000} +: 16];  // Halves are aligned

  always_comb begin
    ext_bit = 1'b0;
    case (size_i)
      ldst_pkg::SIZE_BYTE: begin
        ext_bit = signed_i && byte_sel[7];
        data_o  = {{(ldst_pkg::XLEN-8){ext_bit}}, byte_sel};
      end
      ldst_pkg::SIZE_HALF: begin
        ext_bit = signed_i && half_sel[15];
        data_o  = {{(ldst_pkg::XLEN-16){ext_bit}}, half_sel};
      end
      default: data_o = word_i;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/ldst_buffer.sv
// ==============================
// Load/store buffer top
// Store queue, forwarding, control
// and load alignment
// ==============================
`timescale 1ns/1ps
`default_nettype none

module ldst_buffer (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      flush_i,
  input  logic                      req_valid_i,
  input  logic                      req_we_i,
  input  logic [ldst_pkg::XLEN-1:0] req_addr_i,
  input  ldst_pkg::access_size_e    req_size_i,
  input  logic [ldst_pkg::XLEN-1:0] req_wdata_i,
  input  logic                      req_signed_i,
  output logic                      stall_o,
  output logic                      ld_valid_o,
  output logic [ldst_pkg::XLEN-1:0] ld_data_o,
  output logic                      dc_req_valid_o,
  output logic                      dc_we_o,
  output logic [ldst_pkg::XLEN-1:0] dc_addr_o,
  output ldst_pkg::access_size_e    dc_size_o,
  output logic [ldst_pkg::XLEN-1:0] dc_wdata_o,
  input  logic                      dc_rsp_valid_i,
  input  logic [ldst_pkg::XLEN-1:0] dc_rdata_i
);

  logic                          push, pop, merge_ok, full;
  logic [ldst_pkg::XLEN-1:0]     head_addr, head_data;
  ldst_pkg::byte_mask_t          head_mask;
  logic [ldst_pkg::XLEN-1:0]     ent_addr [ldst_pkg::SB_DEPTH];
  ldst_pkg::byte_mask_t          ent_mask [ldst_pkg::SB_DEPTH];
  logic [ldst_pkg::XLEN-1:0]     ent_data [ldst_pkg::SB_DEPTH];
  logic [ldst_pkg::SB_PTR_W-1:0] tail_ptr;
  logic [ldst_pkg::SB_CNT_W-1:0] count;
  logic                          act_valid;
  logic [ldst_pkg::XLEN-1:0]     act_addr, act_data;
  ldst_pkg::byte_mask_t          act_mask;
  logic                          fwd_hit, fwd_partial;
  logic [ldst_pkg::XLEN-1:0]     fwd_word;
  logic                          ld_from_fwd, ld_signed;
  logic [1:0]                    ld_lsb;
  ldst_pkg::access_size_e        ld_size;
  logic [ldst_pkg::XLEN-1:0]     ld_word;

  store_queue i_store_queue (
    .clk_i, .rst_ni,
    .push_i(push), .pop_i(pop),
    .push_addr_i(req_addr_i), .push_size_i(req_size_i), .push_wdata_i(req_wdata_i),
    .merge_ok_o(merge_ok), .full_o(full),
    .head_addr_o(head_addr), .head_mask_o(head_mask), .head_data_o(head_data),
    .ent_addr_o(ent_addr), .ent_mask_o(ent_mask), .ent_data_o(ent_data),
    .tail_ptr_o(tail_ptr), .count_o(count)
  );

  store_forward i_store_forward (
    .ld_addr_i(req_addr_i), .ld_size_i(req_size_i),
    .ent_addr_i(ent_addr), .ent_mask_i(ent_mask), .ent_data_i(ent_data),
    .tail_ptr_i(tail_ptr), .count_i(count),
    .act_valid_i(act_valid), .act_addr_i(act_addr),
    .act_mask_i(act_mask), .act_data_i(act_data),
    .fwd_hit_o(fwd_hit), .fwd_partial_o(fwd_partial), .fwd_word_o(fwd_word)
  );

  ldst_ctrl i_ldst_ctrl (
    .clk_i, .rst_ni, .flush_i,
    .req_valid_i, .req_we_i, .req_addr_i, .req_size_i, .req_wdata_i, .req_signed_i,
    .merge_ok_i(merge_ok), .full_i(full), .count_i(count),
    .head_addr_i(head_addr), .head_mask_i(head_mask), .head_data_i(head_data),
    .fwd_hit_i(fwd_hit), .fwd_partial_i(fwd_partial),
    .dc_rsp_valid_i,
    .push_o(push), .pop_o(pop),
    .act_valid_o(act_valid), .act_addr_o(act_addr),
    .act_mask_o(act_mask), .act_data_o(act_data),
    .dc_req_valid_o, .dc_we_o, .dc_addr_o, .dc_size_o, .dc_wdata_o,
    .ld_from_fwd_o(ld_from_fwd), .ld_lsb_o(ld_lsb),
    .ld_size_o(ld_size), .ld_signed_o(ld_signed),
    .ld_valid_o, .stall_o
  );

  assign ld_word = ld_from_fwd ? fwd_word : dc_rdata_i;  // Forwarded or cache word

  load_align i_load_align (
    .word_i(ld_word), .lsb_i(ld_lsb), .size_i(ld_size),
    .signed_i(ld_signed), .data_o(ld_data_o)
  );

endmodule

`default_nettype wire

//--- tests/dcache_model.sv
// ==============================
// Behavioral data cache
// Sparse word memory with a set latency,
// a write log and a read count
// ==============================
`timescale 1ns/1ps
`default_nettype none

module dcache_model (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [7:0]             latency_i,
  input  logic                   req_valid_i,
  input  logic                   we_i,
  input  logic [31:0]            addr_i,
  input  ldst_pkg::access_size_e size_i,
  input  logic [31:0]            wdata_i,
  output logic                   rsp_valid_o,
  output logic [31:0]            rdata_o,
  output logic                   busy_o
);

  logic [31:0]            mem [logic [31:0]];  // Sparse word memory
  logic                   pend_q, we_q;
  logic [31:0]            addr_q, wdata_q, rdata_q;
  ldst_pkg::access_size_e size_q;
  logic [7:0]             cnt_q;
  logic [31:0]            log_addr [$];
  logic [1:0]             log_size [$];
  logic [31:0]            log_data [$];
  int                     log_n;
  int                     rd_count;

  function automatic logic [31:0] read_word(input logic [31:0] addr);
    logic [31:0] waddr;
    waddr = {addr[31:2], 2'b00};
    if (mem.exists(waddr)) return mem[waddr];
    return waddr ^ 32'h5A5A_C3C3;  // Fill for untouched words
  endfunction

  assign rsp_valid_o = pend_q && (cnt_q == 8'd0);
  assign rdata_o     = rdata_q;
  assign busy_o      = pend_q;

  always @(posedge clk_i) begin : seq
    logic [31:0] word;
    int          nbytes;
    if (!rst_ni) begin
      pend_q   <= 1'b0;
      cnt_q    <= 8'd0;
      log_n    = 0;
      rd_count = 0;
    end else if (pend_q && (cnt_q != 8'd0)) begin
      cnt_q <= cnt_q - 8'd1;
    end else if (pend_q) begin
      pend_q <= 1'b0;
      if (we_q) begin
        nbytes = (size_q == ldst_pkg::SIZE_BYTE) ? 1 : (size_q == ldst_pkg::SIZE_HALF) ? 2 : 4;
        word   = read_word(addr_q);
        for (int b = 0; b < nbytes; b++) begin
          word[(int'(addr_q[1:0]) + b) * 8 +: 8] = wdata_q[b * 8 +: 8];  // Low lanes placed up
        end
        mem[{addr_q[31:2], 2'b00}] = word;
        log_addr.push_back(addr_q);
        log_size.push_back(size_q);
        log_data.push_back(wdata_q & ~(32'hFFFF_FFFF << (8 * nbytes)));
        log_n++;
      end else begin
        rd_count++;
      end
    end else if (req_valid_i) begin
      pend_q  <= 1'b1;
      we_q    <= we_i;
      addr_q  <= addr_i;
      size_q  <= size_i;
      wdata_q <= wdata_i;
      cnt_q   <= latency_i;
      rdata_q <= read_word(addr_i);  // Memory is stable while a read is pending
    end
  end

endmodule

`default_nettype wire

//--- tests/ldst_buffer_tb.sv
// ==============================
// Load/store buffer testbench
// Directed tests against a behavioral
// data cache with set latency
// ==============================
`timescale 1ns/1ps
`default_nettype none

module ldst_buffer_tb;

  logic                   clk_i, rst_ni, flush_i;
  logic                   req_valid_i, req_we_i, req_signed_i;
  logic [31:0]            req_addr_i, req_wdata_i;
  ldst_pkg::access_size_e req_size_i;
  logic                   stall_o, ld_valid_o;
  logic [31:0]            ld_data_o;
  logic                   dc_req_valid, dc_we, dc_rsp_valid, cache_busy;
  logic [31:0]            dc_addr, dc_wdata, dc_rdata;
  ldst_pkg::access_size_e dc_size;
  logic [7:0]             latency;
  logic [31:0]            lfsr_q;
  int                     checks, errors;

  always #5 clk_i = ~clk_i;

  ldst_buffer i_dut (
    .clk_i, .rst_ni, .flush_i, .req_valid_i, .req_we_i, .req_addr_i, .req_size_i,
    .req_wdata_i, .req_signed_i, .stall_o, .ld_valid_o, .ld_data_o,
    .dc_req_valid_o(dc_req_valid), .dc_we_o(dc_we), .dc_addr_o(dc_addr),
    .dc_size_o(dc_size), .dc_wdata_o(dc_wdata),
    .dc_rsp_valid_i(dc_rsp_valid), .dc_rdata_i(dc_rdata)
  );

  dcache_model i_cache (
    .clk_i, .rst_ni, .latency_i(latency),
    .req_valid_i(dc_req_valid), .we_i(dc_we), .addr_i(dc_addr), .size_i(dc_size),
    .wdata_i(dc_wdata), .rsp_valid_o(dc_rsp_valid), .rdata_o(dc_rdata), .busy_o(cache_busy)
  );

  // ==============================
  // Helpers
  // ==============================
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        b;
    v = '0;
    for (int i = 0; i < n; i++) begin
      b      = lfsr_q[0];
      lfsr_q = lfsr_q >> 1;
      if (b) lfsr_q = lfsr_q ^ 32'hB4BC_D35C;  // Galois taps
      v = {v[30:0], b};
    end
    return v;
  endfunction

  // Lane at the address, widened by sign or zero
  function automatic logic [31:0] expect_load(input logic [31:0] word, input int lsb,
                                              input ldst_pkg::access_size_e size,
                                              input logic sgn);
    logic [31:0] sh;
    sh = word >> (8 * lsb);
    case (size)
      ldst_pkg::SIZE_BYTE: return sgn ? {{24{sh[7]}}, sh[7:0]} : {24'h0, sh[7:0]};
      ldst_pkg::SIZE_HALF: return sgn ? {{16{sh[15]}}, sh[15:0]} : {16'h0, sh[15:0]};
      default:             return word;
    endcase
  endfunction

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic require(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("Failure: %s", what);
    end
  endtask

  task automatic verify_log_entry(input string name, input int idx, input logic [31:0] addr,
                                  input ldst_pkg::access_size_e size, input logic [31:0] data);
    require(idx < i_cache.log_n, $sformatf("%s write is missing from the cache log", name));
    if (idx < i_cache.log_n) begin
      compare_value({name, " addr"}, addr, i_cache.log_addr[idx]);
      compare_value({name, " size"}, 32'(size), 32'(i_cache.log_size[idx]));
      compare_value({name, " data"}, data, i_cache.log_data[idx]);
    end
  endtask

  // Holds the request until stall_o drops, then frees the bus
  task automatic access(input logic we, input logic [31:0] addr,
                        input ldst_pkg::access_size_e size, input logic [31:0] wdata,
                        input logic sgn, output logic [31:0] rdata, output int waits);
    @(negedge clk_i);
    req_valid_i  = 1'b1;
    req_we_i     = we;
    req_addr_i   = addr;
    req_size_i   = size;
    req_wdata_i  = wdata;
    req_signed_i = sgn;
    #1;
    waits = 0;
    while (stall_o && (waits < 200)) begin
      @(negedge clk_i);
      #1;
      waits++;
    end
    if (stall_o) begin
      errors++;
      $display("Timeout: request to %h was never accepted", addr);
    end
    rdata = ld_data_o;
    if (!we) require(ld_valid_o, "load accepted without ld_valid_o");
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  task automatic store(input logic [31:0] addr, input ldst_pkg::access_size_e size,
                       input logic [31:0] wdata);
    logic [31:0] unused_data;
    int          unused_waits;
    access(1'b1, addr, size, wdata, 1'b0, unused_data, unused_waits);
  endtask

  task automatic load_check(input string name, input logic [31:0] addr,
                            input ldst_pkg::access_size_e size, input logic sgn,
                            input logic [31:0] exp, output int waits);
    logic [31:0] got;
    access(1'b0, addr, size, '0, sgn, got, waits);
    compare_value(name, exp, got);
  endtask

  task automatic wait_writes(input int n);
    int t;
    t = 0;
    while (((i_cache.log_n < n) || cache_busy) && (t < 300)) begin
      @(negedge clk_i);
      t++;
    end
    if ((i_cache.log_n < n) || cache_busy) begin
      errors++;
      $display("Timeout: cache never logged %0d writes", n);
    end
  endtask

  // ==============================
  // Directed tests
  // ==============================
  task automatic load_extension();
    logic [31:0]            w;
    ldst_pkg::access_size_e sz;
    int                     off;
    int                     waits;
    latency = 8'd2;
    w       = 32'h80F1_7E82;  // Both sign polarities in bytes and halves
    off     = i_cache.log_n;
    store(32'h100, ldst_pkg::SIZE_WORD, w);
    wait_writes(off + 1);
    for (int k = 0; k < 7; k++) begin
      for (int s = 0; s < 2; s++) begin
        off = (k < 4) ? k : (k < 6) ? 2 * (k - 4) : 0;
        sz  = (k < 4) ? ldst_pkg::SIZE_BYTE : (k < 6) ? ldst_pkg::SIZE_HALF : ldst_pkg::SIZE_WORD;
        load_check($sformatf("extend size %0d off %0d signed %0d", sz, off, s),
                   32'h100 + off, sz, s[0], expect_load(w, off, sz, s[0]), waits);
      end
    end
  endtask

  task automatic store_forwarding();
    logic [31:0]            r0, r1;
    ldst_pkg::access_size_e sz;
    int                     off, base, reads, waits;
    latency = 8'd40;
    r0      = rand_bits(32);
    r1      = rand_bits(32);
    base    = i_cache.log_n;
    reads   = i_cache.rd_count;
    store(32'h200, ldst_pkg::SIZE_WORD, r0);  // Goes in flight
    store(32'h204, ldst_pkg::SIZE_WORD, r1);  // Stays queued
    for (int w = 0; w < 2; w++) begin
      for (int k = 0; k < 7; k++) begin
        off = (k < 4) ? k : (k < 6) ? 2 * (k - 4) : 0;
        sz  = (k < 4) ? ldst_pkg::SIZE_BYTE : (k < 6) ? ldst_pkg::SIZE_HALF : ldst_pkg::SIZE_WORD;
        load_check($sformatf("forward word %0d size %0d off %0d", w, sz, off),
                   32'h200 + 4 * w + off, sz, k[0], expect_load(w ? r1 : r0, off, sz, k[0]), waits);
        compare_value("forward wait cycles", 0, waits);
      end
    end
    compare_value("forward cache reads", reads, i_cache.rd_count);
    wait_writes(base + 2);
  endtask

  task automatic store_merging();
    logic [31:0] a, b0, b1, c0, c2;
    int          base;
    latency = 8'd20;
    base    = i_cache.log_n;
    a       = rand_bits(32);
    b0      = rand_bits(8);
    b1      = rand_bits(8);
    c0      = rand_bits(8);
    c2      = rand_bits(8);
    store(32'h300, ldst_pkg::SIZE_WORD, a);  // Keeps the cache busy
    store(32'h304, ldst_pkg::SIZE_BYTE, b0);
    store(32'h305, ldst_pkg::SIZE_BYTE, b1);
    store(32'h308, ldst_pkg::SIZE_BYTE, c0);
    store(32'h30A, ldst_pkg::SIZE_BYTE, c2);  // Lanes 0 and 2 do not merge
    wait_writes(base + 4);
    compare_value("merge write count", base + 4, i_cache.log_n);
    verify_log_entry("merge word", base, 32'h300, ldst_pkg::SIZE_WORD, a);
    verify_log_entry("merge half", base + 1, 32'h304, ldst_pkg::SIZE_HALF,
                     {16'h0, b1[7:0], b0[7:0]});
    verify_log_entry("split low", base + 2, 32'h308, ldst_pkg::SIZE_BYTE, {24'h0, c0[7:0]});
    verify_log_entry("split high", base + 3, 32'h30A, ldst_pkg::SIZE_BYTE, {24'h0, c2[7:0]});
  endtask

  task automatic partial_overlap();
    logic [31:0] p, x;
    int          base, waits;
    latency = 8'd3;
    p       = rand_bits(32);
    x       = rand_bits(8);
    base    = i_cache.log_n;
    store(32'h400, ldst_pkg::SIZE_WORD, p);
    wait_writes(base + 1);
    latency = 8'd8;
    store(32'h401, ldst_pkg::SIZE_BYTE, x);
    load_check("partial word", 32'h400, ldst_pkg::SIZE_WORD, 1'b0, {p[31:16], x[7:0], p[7:0]},
               waits);
    require(waits > 0, "partially overlapping load was not stalled");
    require(i_cache.log_n >= base + 2, "partial load finished before its store was written");
  endtask

  task automatic full_backpressure();
    logic [31:0] data [$];
    logic [31:0] unused_data;
    logic        stalled;
    int          base, waits;
    latency = 8'd20;
    base    = i_cache.log_n;
    stalled = 1'b0;
    for (int i = 0; i < 6; i++) begin
      data.push_back(rand_bits(32));
      access(1'b1, 32'h500 + 4 * i, ldst_pkg::SIZE_WORD, data[i], 1'b0, unused_data, waits);
      if (waits > 0) stalled = 1'b1;
    end
    require(stalled, "stall_o never rose while the store queue was full");
    wait_writes(base + 6);
    for (int i = 0; i < 6; i++) begin
      verify_log_entry($sformatf("order %0d", i), base + i, 32'h500 + 4 * i,
                       ldst_pkg::SIZE_WORD, data[i]);
    end
  endtask

  task automatic flush_drain();
    logic [31:0] data [$];
    int          base, t, waits;
    latency = 8'd6;
    base    = i_cache.log_n;
    for (int i = 0; i < 3; i++) begin
      data.push_back(rand_bits(32));
      store(32'h600 + 4 * i, ldst_pkg::SIZE_WORD, data[i]);
    end
    @(negedge clk_i);
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    #1;
    require(stall_o, "stall_o low after flush with stores pending");
    t = 0;
    while (stall_o && (t < 300)) begin
      @(negedge clk_i);
      #1;
      t++;
    end
    if (stall_o) begin
      errors++;
      $display("Timeout: drain mode never ended");
    end
    compare_value("flush write count", base + 3, i_cache.log_n);
    require(!cache_busy, "cache transaction still active when the drain ended");
    for (int i = 0; i < 3; i++) begin
      load_check($sformatf("flush readback %0d", i), 32'h600 + 4 * i, ldst_pkg::SIZE_WORD, 1'b0,
                 data[i], waits);
    end
  endtask

  initial begin
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    flush_i      = 1'b0;
    req_valid_i  = 1'b0;
    req_we_i     = 1'b0;
    req_addr_i   = '0;
    req_size_i   = ldst_pkg::SIZE_WORD;
    req_wdata_i  = '0;
    req_signed_i = 1'b0;
    latency      = 8'd0;
    lfsr_q       = 32'd60;
    checks       = 0;
    errors       = 0;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    require(!stall_o && !ld_valid_o && !dc_req_valid, "outputs not idle after reset");
    load_extension();
    store_forwarding();
    store_merging();
    partial_overlap();
    full_backpressure();
    flush_drain();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
logic/ldst_pkg.sv
logic/store_queue.sv
logic/store_forward.sv
logic/ldst_ctrl.sv
logic/load_align.sv
logic/ldst_buffer.sv
tests/dcache_model.sv
tests/ldst_buffer_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module ldst_buffer_tb -f list.f
	@out="$$(./obj_dir/Vldst_buffer_tb)"; echo "$$out"; echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir
